/* Makefile */
TOP = tb_maxflow_task_unit

all: build run

build:
	verilator --binary --timing --assert -f maxflow_task_unit.f --top-module $(TOP) -Mdir obj_dir

run:
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^TEST OK$$" sim.log

lint:
	verilator --lint-only --timing -f maxflow_task_unit.f --top-module maxflow_task_unit

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* maxflow_cfg_regs.sv */
`timescale 1ns/1ps
`include "maxflow_consts.svh"

module maxflow_cfg_regs (
   input  logic                       clk,
   input  logic                       rstn,
   input  maxflow_pkg::mf_cfg_bus_t   cfg,
   output maxflow_pkg::mf_graph_cfg_t graph
);

   // single-cycle writes, no handshake
   always_ff @(posedge clk) begin
      if (!rstn) begin
         graph <= '0;
      end else if (cfg.wvalid) begin
         case (cfg.waddr)
            `MF_CFG_NUM_V: begin
               graph.num_v <= cfg.wdata[`MF_VID_W-1:0];
            end
            `MF_CFG_SOURCE: begin
               graph.source <= cfg.wdata[`MF_VID_W-1:0];
            end
            `MF_CFG_SINK: begin
               graph.sink <= cfg.wdata[`MF_VID_W-1:0];
            end
            default: begin
               // store regions are decoded by the stages
            end
         endcase
      end
   end

endmodule

/* maxflow_consts.svh */
`ifndef MAXFLOW_CONSTS_SVH
`define MAXFLOW_CONSTS_SVH

// store depths
`define MF_NUM_VTX      16
`define MF_NUM_EDGES    64
`define MF_MAX_DEG      4
`define MF_VTX_WORDS    4

// field widths
`define MF_WORD_W       32
`define MF_VID_W        8
`define MF_EIDX_W       2
`define MF_HEIGHT_W     12
`define MF_FLOW_W       16
`define MF_EADDR_W      8
`define MF_CNT_W        4
`define MF_CFG_AW       16

// graph parameter registers
`define MF_CFG_NUM_V    16'd4
`define MF_CFG_SOURCE   16'd8
`define MF_CFG_SINK     16'd12

// vertex word address = region + vtx*4 + word
`define MF_VTX_REGION   16'h1000
// edge address = region + edge index
`define MF_EDGE_REGION  16'h2000

`endif

/* maxflow_edge_expand.sv */
`timescale 1ns/1ps
`include "maxflow_consts.svh"

module maxflow_edge_expand (
   input  logic                     clk,
   input  logic                     rstn,
   input  maxflow_pkg::mf_cfg_bus_t cfg,
   input  logic                     upd_valid,
   output logic                     upd_ready,
   input  maxflow_pkg::mf_task_t    upd_task,
   output logic                     out_valid,
   input  logic                     out_ready,
   output maxflow_pkg::mf_task_t    out_task
);

   localparam int EW = $clog2(`MF_NUM_EDGES);

   typedef enum logic [1:0] {
      st_idle,
      st_fanout,
      st_second
   } exp_state_e;

   maxflow_pkg::mf_edge_t edge_mem [`MF_NUM_EDGES];

   exp_state_e            state, nxt_state;
   logic [`MF_CFG_AW-1:0] edge_off;
   logic                  edge_hit;
   logic                  adv, nxt_valid, ld_par;
   maxflow_pkg::eaddr_t   cur, nxt_cur, pos;
   maxflow_pkg::mf_edge_t edge_rd;
   maxflow_pkg::mf_task_t par, nxt_task;

   assign edge_off  = cfg.waddr - `MF_EDGE_REGION;
   assign edge_hit  = cfg.wvalid && (edge_off < 16'(`MF_NUM_EDGES));
   assign edge_rd   = edge_mem[cur[EW-1:0]];
   // output slot free or draining this cycle
   assign adv       = !out_valid || out_ready;
   assign upd_ready = (state == st_idle) && adv;

   always_comb begin
      nxt_state = state;
      nxt_cur   = cur;
      nxt_valid = 1'b0;
      nxt_task  = '0;
      ld_par    = 1'b0;
      pos       = cur - par.eo_begin;
      case (state)
         st_idle: begin
            if (upd_valid && upd_ready) begin
               case (upd_task.ttype)
                  maxflow_pkg::mf_discharge: begin
                     if (upd_task.eo_begin != upd_task.eo_end) begin
                        ld_par    = 1'b1;
                        nxt_cur   = upd_task.eo_begin;
                        nxt_state = st_fanout;
                     end
                  end
                  maxflow_pkg::mf_get_height: begin
                     nxt_valid         = 1'b1;
                     nxt_task.ttype    = maxflow_pkg::mf_push;
                     nxt_task.locale   = upd_task.peer;
                     nxt_task.peer     = upd_task.locale;
                     nxt_task.fwd_edge = upd_task.fwd_edge;
                     nxt_task.rev_edge = upd_task.rev_edge;
                     nxt_task.cap      = upd_task.cap;
                     nxt_task.height   = upd_task.height;
                  end
                  maxflow_pkg::mf_push: begin
                     if (upd_task.flow > 0) begin
                        nxt_valid         = 1'b1;
                        nxt_task.ttype    = maxflow_pkg::mf_receive;
                        nxt_task.locale   = upd_task.peer;
                        nxt_task.peer     = upd_task.locale;
                        nxt_task.rev_edge = upd_task.rev_edge;
                        nxt_task.cap      = upd_task.cap;
                        nxt_task.flow     = upd_task.flow;
                        // discharge follows next cycle
                        if (upd_task.reenqueue) begin
                           ld_par    = 1'b1;
                           nxt_state = st_second;
                        end
                     end else if (upd_task.reenqueue) begin
                        nxt_valid       = 1'b1;
                        nxt_task.ttype  = maxflow_pkg::mf_discharge;
                        nxt_task.locale = upd_task.locale;
                     end
                  end
                  maxflow_pkg::mf_receive: begin
                     if (upd_task.reenqueue) begin
                        nxt_valid       = 1'b1;
                        nxt_task.ttype  = maxflow_pkg::mf_discharge;
                        nxt_task.locale = upd_task.locale;
                     end
                  end
               endcase
            end
         end
         st_fanout: begin
            if (adv) begin
               nxt_valid         = 1'b1;
               nxt_task.ttype    = maxflow_pkg::mf_get_height;
               nxt_task.locale   = edge_rd.dest;
               nxt_task.peer     = par.locale;
               nxt_task.fwd_edge = pos[`MF_EIDX_W-1:0];
               nxt_task.rev_edge = edge_rd.rev_edge;
               nxt_task.cap      = edge_rd.cap;
               nxt_cur           = cur + 1'b1;
               if (nxt_cur == par.eo_end) begin
                  nxt_state = st_idle;
               end
            end
         end
         default: begin
            if (adv) begin
               nxt_valid       = 1'b1;
               nxt_task.ttype  = maxflow_pkg::mf_discharge;
               nxt_task.locale = par.locale;
               nxt_state       = st_idle;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state     <= st_idle;
         cur       <= '0;
         out_valid <= 1'b0;
      end else begin
         state <= nxt_state;
         cur   <= nxt_cur;
         if (adv) begin
            out_valid <= nxt_valid;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (adv && nxt_valid) begin
         out_task <= nxt_task;
      end
      if (ld_par) begin
         par <= upd_task;
      end
      if (edge_hit) begin
         edge_mem[edge_off[EW-1:0]] <= cfg.wdata;
      end
   end

endmodule

/* maxflow_pkg.sv */
`include "maxflow_consts.svh"

package maxflow_pkg;

   typedef logic [`MF_VID_W-1:0] vid_t;
   typedef logic [`MF_EIDX_W-1:0] edge_idx_t;
   typedef logic [`MF_HEIGHT_W-1:0] height_t;
   typedef logic signed [`MF_FLOW_W-1:0] flow_t;
   typedef logic [`MF_EADDR_W-1:0] eaddr_t;

   typedef enum logic [1:0] {
      mf_discharge  = 2'd0,
      mf_get_height = 2'd1,
      mf_push       = 2'd2,
      mf_receive    = 2'd3
   } mf_ttype_e;

   typedef struct packed {
      mf_ttype_e  ttype;
      vid_t       locale;
      vid_t       peer;
      edge_idx_t  fwd_edge;
      edge_idx_t  rev_edge;
      flow_t      cap;
      height_t    height;
      flow_t      flow;
      eaddr_t     eo_begin;
      eaddr_t     eo_end;
      logic       reenqueue;
   } mf_task_t;

   // words 3..2 hold the flows, word 1 edge range and excess, word 0 heights
   typedef struct packed {
      flow_t [`MF_MAX_DEG-1:0] flow;
      eaddr_t                  eo_end;
      eaddr_t                  eo_begin;
      flow_t                   excess;
      logic [3:0]              pad;
      logic [`MF_CNT_W-1:0]    counter;
      height_t                 min_height;
      height_t                 height;
   } mf_vertex_t;

   typedef struct packed {
      flow_t      cap;
      logic [5:0] pad;
      edge_idx_t  rev_edge;
      vid_t       dest;
   } mf_edge_t;

   typedef struct packed {
      logic                  wvalid;
      logic [`MF_CFG_AW-1:0] waddr;
      logic [`MF_WORD_W-1:0] wdata;
   } mf_cfg_bus_t;

   typedef struct packed {
      vid_t num_v;
      vid_t source;
      vid_t sink;
   } mf_graph_cfg_t;

endpackage

/* maxflow_task_unit.f */
+incdir+.
maxflow_pkg.sv
maxflow_cfg_regs.sv
maxflow_vertex_stage.sv
maxflow_edge_expand.sv
maxflow_task_unit.sv
maxflow_task_unit_properties.sv
tb_maxflow_task_unit.sv

/* maxflow_task_unit.sv */
`timescale 1ns/1ps

module maxflow_task_unit (
   input  logic                     clk,
   input  logic                     rstn,
   input  maxflow_pkg::mf_cfg_bus_t cfg,
   input  logic                     in_valid,
   output logic                     in_ready,
   input  maxflow_pkg::mf_task_t    in_task,
   output logic                     out_valid,
   input  logic                     out_ready,
   output maxflow_pkg::mf_task_t    out_task
);

   maxflow_pkg::mf_graph_cfg_t graph;
   logic                       upd_valid;
   logic                       upd_ready;
   maxflow_pkg::mf_task_t      upd_task;

   maxflow_cfg_regs cfg_regs_i (
      .clk   (clk),
      .rstn  (rstn),
      .cfg   (cfg),
      .graph (graph)
   );

   // read-write side, owns the vertex records
   maxflow_vertex_stage vertex_stage_i (
      .clk       (clk),
      .rstn      (rstn),
      .cfg       (cfg),
      .graph     (graph),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_task   (in_task),
      .upd_valid (upd_valid),
      .upd_ready (upd_ready),
      .upd_task  (upd_task)
   );

   // read-only side, edge list walk and child generation
   maxflow_edge_expand edge_expand_i (
      .clk       (clk),
      .rstn      (rstn),
      .cfg       (cfg),
      .upd_valid (upd_valid),
      .upd_ready (upd_ready),
      .upd_task  (upd_task),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_task  (out_task)
   );

endmodule

/* maxflow_task_unit_properties.sv */
`timescale 1ns/1ps

module maxflow_task_unit_properties (
   input logic                  clk,
   input logic                  rstn,
   input logic                  in_ready,
   input logic                  out_valid,
   input logic                  out_ready,
   input maxflow_pkg::mf_task_t out_task
);

   logic rst_d;

   always_ff @(posedge clk) begin
      rst_d <= !rstn;
   end

   // child output holds until taken
   a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
      out_valid && !out_ready |=> out_valid && $stable(out_task))
      else $error("out_valid or out_task changed while stalled");

   a_reset_ready: assert property (@(posedge clk)
      !rstn && rst_d |-> !in_ready)
      else $error("in_ready high during reset");

   // receive cap is copied from the push that made it
   a_recv_flow: assert property (@(posedge clk) disable iff (!rstn)
      out_valid && out_task.ttype == maxflow_pkg::mf_receive |-> out_task.flow <= out_task.cap)
      else $error("receive flow exceeds push capacity");

endmodule

bind maxflow_task_unit maxflow_task_unit_properties props_i (
   .clk       (clk),
   .rstn      (rstn),
   .in_ready  (in_ready),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_task  (out_task)
);

/* maxflow_vertex_stage.sv */
`timescale 1ns/1ps
`include "maxflow_consts.svh"

module maxflow_vertex_stage (
   input  logic                       clk,
   input  logic                       rstn,
   input  maxflow_pkg::mf_cfg_bus_t   cfg,
   input  maxflow_pkg::mf_graph_cfg_t graph,
   input  logic                       in_valid,
   output logic                       in_ready,
   input  maxflow_pkg::mf_task_t      in_task,
   output logic                       upd_valid,
   input  logic                       upd_ready,
   output maxflow_pkg::mf_task_t      upd_task
);

   localparam int VW = $clog2(`MF_NUM_VTX);
   localparam int WW = $clog2(`MF_VTX_WORDS);

   logic [`MF_VTX_WORDS-1:0][`MF_WORD_W-1:0] vtx_mem [`MF_NUM_VTX];

   logic [`MF_CFG_AW-1:0] vtx_off;
   logic                  vtx_hit;
   logic                  started;
   logic                  a_valid, b_valid;
   logic                  in_fire, upd_fire, a_move;
   maxflow_pkg::mf_task_t    a_task, b_task;
   maxflow_pkg::mf_vertex_t  a_rec, b_rec, mem_rd, new_rec;
   maxflow_pkg::flow_t       fwd_flow, resid, amt;
   maxflow_pkg::eaddr_t      deg;
   maxflow_pkg::height_t     nbr_h1;

   assign vtx_off = cfg.waddr - `MF_VTX_REGION;
   assign vtx_hit = cfg.wvalid && (vtx_off < 16'(`MF_NUM_VTX * `MF_VTX_WORDS));

   assign upd_fire  = b_valid && upd_ready;
   assign a_move    = a_valid && (!b_valid || upd_fire);
   assign in_ready  = started && (!a_valid || a_move);
   assign in_fire   = in_valid && in_ready;
   assign upd_valid = b_valid;
   assign mem_rd    = vtx_mem[in_task.locale[VW-1:0]];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         started <= 1'b0;
         a_valid <= 1'b0;
         b_valid <= 1'b0;
      end else begin
         started <= 1'b1;
         if (in_fire) begin
            a_valid <= 1'b1;
         end else if (a_move) begin
            a_valid <= 1'b0;
         end
         if (a_move) begin
            b_valid <= 1'b1;
         end else if (upd_fire) begin
            b_valid <= 1'b0;
         end
      end
   end

   // forward the record being written back to a younger task on the same vertex
   always_ff @(posedge clk) begin
      if (in_fire) begin
         a_task <= in_task;
         a_rec  <= (upd_fire && b_task.locale == in_task.locale) ? new_rec : mem_rd;
      end
      if (a_move) begin
         b_task <= a_task;
         b_rec  <= (upd_fire && b_task.locale == a_task.locale) ? new_rec : a_rec;
      end
      if (upd_fire) begin
         vtx_mem[b_task.locale[VW-1:0]] <= new_rec;
      end else if (vtx_hit) begin
         vtx_mem[vtx_off[WW +: VW]][vtx_off[WW-1:0]] <= cfg.wdata;
      end
   end

   always_comb begin
      new_rec  = b_rec;
      upd_task = b_task;
      upd_task.reenqueue = 1'b0;
      fwd_flow = b_rec.flow[b_task.fwd_edge];
      resid    = b_task.cap - fwd_flow;
      amt      = '0;
      deg      = b_rec.eo_end - b_rec.eo_begin;
      nbr_h1   = b_task.height + 1'b1;
      case (b_task.ttype)
         maxflow_pkg::mf_discharge: begin
            new_rec.counter    = deg[`MF_CNT_W-1:0];
            new_rec.min_height = maxflow_pkg::height_t'(graph.num_v) << 1;
            upd_task.eo_begin  = b_rec.eo_begin;
            upd_task.eo_end    = b_rec.eo_end;
         end
         maxflow_pkg::mf_get_height: begin
            upd_task.height = b_rec.height;
         end
         maxflow_pkg::mf_push: begin
            new_rec.counter = b_rec.counter - 1'b1;
            // only downhill, except out of the source
            if (nbr_h1 == b_rec.height || b_task.locale == graph.source) begin
               amt = (b_rec.excess > resid) ? resid : b_rec.excess;
            end
            if (amt < 0) begin
               amt = '0;
            end
            if (amt > 0) begin
               new_rec.flow[b_task.fwd_edge] = fwd_flow + amt;
               new_rec.excess = b_rec.excess - amt;
            end
            // edge still residual, candidate for relabel
            if (b_task.cap > new_rec.flow[b_task.fwd_edge] &&
                b_task.height < b_rec.min_height) begin
               new_rec.min_height = b_task.height;
            end
            if (new_rec.counter == 0 && new_rec.excess > 0) begin
               new_rec.height     = new_rec.min_height + 1'b1;
               upd_task.reenqueue = 1'b1;
            end
            upd_task.flow = amt;
         end
         maxflow_pkg::mf_receive: begin
            new_rec.excess = b_rec.excess + b_task.flow;
            new_rec.flow[b_task.rev_edge] = b_rec.flow[b_task.rev_edge] - b_task.flow;
            // wake an idle interior vertex
            upd_task.reenqueue = (b_rec.excess == 0) &&
                                 (b_task.locale != graph.source) &&
                                 (b_task.locale != graph.sink);
         end
      endcase
   end

endmodule

/* tb_maxflow_task_unit.sv */
`timescale 1ns/1ps
`include "maxflow_consts.svh"

module tb_maxflow_task_unit;

   localparam int NSTEPS  = 13;
   localparam int TIMEOUT = 200 * NSTEPS;

   logic                       clk = 1'b0;
   logic                       rstn;
   maxflow_pkg::mf_cfg_bus_t   cfg;
   logic                       in_valid;
   logic                       in_ready;
   maxflow_pkg::mf_task_t      in_task;
   logic                       out_valid;
   logic                       out_ready;
   maxflow_pkg::mf_task_t      out_task;

   string                 step_name [NSTEPS];
   maxflow_pkg::mf_task_t step_in   [NSTEPS][2];
   int                    n_in      [NSTEPS];
   maxflow_pkg::mf_task_t step_exp  [NSTEPS][4];
   int                    n_exp     [NSTEPS];

   logic [31:0] rng = 32'h934a_2ff8;
   int          cycles = 0;
   int          errors = 0;

   maxflow_task_unit maxflow_task_unit_i (.*);

   always #20 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // random stalls on the child output
   always @(posedge clk) begin
      rng       <= xorshift(rng);
      out_ready <= rng[0] | rng[3];
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("timeout after %0d cycles, child tasks missing or unit stuck", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic maxflow_pkg::mf_task_t make_task(
      input maxflow_pkg::mf_ttype_e tt, input int loc, input int peer, input int fwd,
      input int rev, input int cap, input int height, input int flow);
      maxflow_pkg::mf_task_t t;
      t          = '0;
      t.ttype    = tt;
      t.locale   = loc[7:0];
      t.peer     = peer[7:0];
      t.fwd_edge = fwd[1:0];
      t.rev_edge = rev[1:0];
      t.cap      = cap[15:0];
      t.height   = height[11:0];
      t.flow     = flow[15:0];
      return t;
   endfunction

   task automatic write_cfg(input logic [15:0] addr, input logic [31:0] data);
      cfg.wvalid <= 1'b1;
      cfg.waddr  <= addr;
      cfg.wdata  <= data;
      @(posedge clk);
   endtask

   task automatic load_vertex(input int v, input int height, input int excess,
                              input int eb, input int ee);
      maxflow_pkg::mf_vertex_t rec;
      logic [127:0]            bits;
      rec          = '0;
      rec.height   = height[11:0];
      rec.excess   = excess[15:0];
      rec.eo_begin = eb[7:0];
      rec.eo_end   = ee[7:0];
      bits         = rec;
      for (int w = 0; w < `MF_VTX_WORDS; w++) begin
         write_cfg(`MF_VTX_REGION + 16'(v * 4 + w), bits[w*32 +: 32]);
      end
   endtask

   task automatic load_edge(input int idx, input int dest, input int rev, input int cap);
      maxflow_pkg::mf_edge_t e;
      e          = '0;
      e.dest     = dest[7:0];
      e.rev_edge = rev[1:0];
      e.cap      = cap[15:0];
      write_cfg(`MF_EDGE_REGION + 16'(idx), e);
   endtask

   task automatic send_task(input maxflow_pkg::mf_task_t t);
      in_valid <= 1'b1;
      in_task  <= t;
      do @(posedge clk); while (!in_ready);
      in_valid <= 1'b0;
   endtask

   task automatic collect_children(input int s);
      int got;
      got = 0;
      while (got < n_exp[s]) begin
         @(posedge clk);
         if (out_valid && out_ready) begin
            if (out_task !== step_exp[s][got]) begin
               $display("MISMATCH %s child %0d: expected %h actual %h",
                        step_name[s], got, step_exp[s][got], out_task);
               errors++;
            end
            got++;
         end
      end
   endtask

   task automatic add_step(input int s, input string name, input int ni, input int ne);
      step_name[s] = name;
      n_in[s]      = ni;
      n_exp[s]     = ne;
   endtask

   task automatic build_table();
      maxflow_pkg::mf_task_t gh0, gh1, psh, psh2;
      gh0  = make_task(maxflow_pkg::mf_get_height, 1, 0, 0, 0, 10, 0, 0);
      gh1  = make_task(maxflow_pkg::mf_get_height, 2, 0, 1, 1, 15, 0, 0);
      psh  = make_task(maxflow_pkg::mf_push, 0, 1, 0, 0, 10, 0, 0);
      psh2 = make_task(maxflow_pkg::mf_push, 0, 2, 1, 1, 15, 3, 0);
      add_step(0, "disch_src", 1, 2);
      step_in[0][0]  = make_task(maxflow_pkg::mf_discharge, 0, 0, 0, 0, 0, 0, 0);
      step_exp[0][0] = gh0;
      step_exp[0][1] = gh1;
      add_step(1, "disch_empty", 1, 0);
      step_in[1][0]  = make_task(maxflow_pkg::mf_discharge, 3, 0, 0, 0, 0, 0, 0);
      // vertex 2 sits at height 3
      add_step(2, "get_height", 1, 1);
      step_in[2][0]  = gh1;
      step_exp[2][0] = psh2;
      add_step(3, "push_src", 1, 1);
      step_in[3][0]  = psh;
      step_exp[3][0] = make_task(maxflow_pkg::mf_receive, 1, 0, 0, 0, 10, 0, 10);
      add_step(4, "redisch_src", 1, 2);
      step_in[4][0]  = step_in[0][0];
      step_exp[4][0] = gh0;
      step_exp[4][1] = gh1;
      // edge already saturated
      add_step(5, "push_full", 1, 0);
      step_in[5][0]  = psh;
      add_step(6, "recv_idle", 1, 1);
      step_in[6][0]  = make_task(maxflow_pkg::mf_receive, 1, 0, 0, 0, 10, 0, 10);
      step_exp[6][0] = make_task(maxflow_pkg::mf_discharge, 1, 0, 0, 0, 0, 0, 0);
      add_step(7, "recv_sink", 1, 0);
      step_in[7][0]  = make_task(maxflow_pkg::mf_receive, 3, 2, 0, 1, 15, 0, 5);
      add_step(8, "disch_mid", 1, 2);
      step_in[8][0]  = make_task(maxflow_pkg::mf_discharge, 1, 0, 0, 0, 0, 0, 0);
      step_exp[8][0] = make_task(maxflow_pkg::mf_get_height, 0, 1, 0, 0, 0, 0, 0);
      step_exp[8][1] = make_task(maxflow_pkg::mf_get_height, 3, 1, 1, 0, 10, 0, 0);
      add_step(9, "push_uphill", 1, 0);
      step_in[9][0]  = make_task(maxflow_pkg::mf_push, 1, 3, 1, 0, 10, 5, 0);
      // last edge with excess left, relabel and requeue
      add_step(10, "push_last", 1, 1);
      step_in[10][0]  = make_task(maxflow_pkg::mf_push, 1, 0, 0, 0, 0, 4, 0);
      step_exp[10][0] = make_task(maxflow_pkg::mf_discharge, 1, 0, 0, 0, 0, 0, 0);
      add_step(11, "redisch_src2", 1, 2);
      step_in[11][0]  = step_in[0][0];
      step_exp[11][0] = gh0;
      step_exp[11][1] = gh1;
      // second push sees the drained excess only through forwarding
      add_step(12, "push_pair", 2, 1);
      step_in[12][0]  = psh2;
      step_in[12][1]  = psh2;
      step_exp[12][0] = make_task(maxflow_pkg::mf_receive, 2, 0, 0, 1, 15, 0, 10);
   endtask

   initial begin
      rstn     = 1'b0;
      cfg      = '0;
      in_valid = 1'b0;
      in_task  = '0;
      out_ready = 1'b0;
      build_table();
      repeat (8) @(posedge clk);
      rstn <= 1'b1;
      @(posedge clk);
      write_cfg(`MF_CFG_NUM_V, 32'd4);
      write_cfg(`MF_CFG_SOURCE, 32'd0);
      write_cfg(`MF_CFG_SINK, 32'd3);
      load_vertex(0, 4, 20, 0, 2);
      load_vertex(1, 0, 0, 2, 4);
      load_vertex(2, 3, 0, 4, 6);
      load_vertex(3, 0, 0, 6, 6);
      load_edge(0, 1, 0, 10);
      load_edge(1, 2, 1, 15);
      load_edge(2, 0, 0, 0);
      load_edge(3, 3, 0, 10);
      load_edge(4, 3, 0, 15);
      load_edge(5, 0, 1, 0);
      cfg <= '0;
      @(posedge clk);
      for (int s = 0; s < NSTEPS; s++) begin
         fork
            begin
               for (int i = 0; i < n_in[s]; i++) begin
                  send_task(step_in[s][i]);
               end
            end
            collect_children(s);
         join
         // nothing more may follow
         for (int c = 0; c < 12; c++) begin
            @(posedge clk);
            if (out_valid) begin
               $display("step %s produced more child tasks than expected", step_name[s]);
               errors++;
               break;
            end
         end
      end
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
